/* source/mem_defs.svh */
// Sizing macros for the graphics memory subsystem
// Word and pixel layout, frame geometry, queue depth, read latency

`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Memory word and pixel layout
`define MEM_WORD_BITS   128
`define PIXELS_PER_WORD 4
`define PIXEL_BITS      32
`define COLOR_BITS      24
`define ADDR_BITS       31
`define CMD_BITS        3

// Frame geometry
`define FRAME_WORDS     16
`define FRAME_COUNT     2
`define FRAME_SEL_BITS  $clog2(`FRAME_COUNT)
`define MEM_DEPTH       (`FRAME_COUNT * `FRAME_WORDS)

// dram_model queues and read pipeline
`define QUEUE_DEPTH     4
`define READ_LATENCY    3

`endif

/* source/mem_pkg.sv */
// Types shared by the memory subsystem
// Command encoding, address queue entry, the two views of a memory word
// and the frame address helper used by both clients

`include "mem_defs.svh"

package mem_pkg;

    // Command codes carried in the address queue
    typedef enum logic [`CMD_BITS-1:0] {
        CMD_WRITE = 3'b000,
        CMD_READ  = 3'b001
    } mem_cmd_t;

    // One address queue entry, command in the top bits
    typedef struct packed {
        mem_cmd_t              cmd;
        logic [`ADDR_BITS-1:0] addr;
    } af_entry_t;

    // A memory word, raw or split into pixels (pixel 0 in the low bits)
    typedef union packed {
        logic [`MEM_WORD_BITS-1:0]                    raw;
        logic [`PIXELS_PER_WORD-1:0][`PIXEL_BITS-1:0] pixels;
    } mem_word_u;

    // Word address of a word inside a frame
    function automatic logic [`ADDR_BITS-1:0] word_addr(
        input logic [31:0] frame,
        input logic [31:0] word
    );
        logic [31:0] addr;
        addr = frame * `FRAME_WORDS + word;
        return addr[`ADDR_BITS-1:0];
    endfunction

endpackage

/* source/frame_filler.sv */
// Frame filler
// Paints a whole frame buffer in one color with whole-word writes,
// pushing a write command and its data together

`timescale 1ns/1ps
`include "mem_defs.svh"

module frame_filler (
    input  logic                       cpu_clk_g,
    input  logic                       i_reset,
    // Fill request
    input  logic                       i_fill_valid,
    input  logic [`COLOR_BITS-1:0]     i_fill_color,
    input  logic [`FRAME_SEL_BITS-1:0] i_fill_frame,
    output logic                       o_fill_ready,
    // Write path toward the request controller
    input  logic                       i_af_full,
    input  logic                       i_wdf_full,
    output logic                       o_af_wr_en,
    output mem_pkg::af_entry_t         o_af_entry,
    output logic                       o_wdf_wr_en,
    output mem_pkg::mem_word_u         o_wdf_din
);

    import mem_pkg::*;

    localparam int WORD_BITS = $clog2(`FRAME_WORDS);

    logic                       busy;
    logic [`COLOR_BITS-1:0]     color;
    logic [`FRAME_SEL_BITS-1:0] frame;
    logic [WORD_BITS-1:0]       word;
    logic                       push;

    // A word goes out only when both queues have room
    assign push = busy && !i_af_full && !i_wdf_full;

    always_ff @(posedge cpu_clk_g) begin
        if (i_reset) begin
            busy <= 1'b0;
            word <= '0;
        end else if (!busy) begin
            if (i_fill_valid) begin
                busy <= 1'b1;
                word <= '0;
            end
        end else if (push) begin
            word <= word + 1'b1;
            if (word == WORD_BITS'(`FRAME_WORDS - 1)) begin
                busy <= 1'b0;
            end
        end
    end

    // Request payload
    always_ff @(posedge cpu_clk_g) begin
        if (!busy && i_fill_valid) begin
            color <= i_fill_color;
            frame <= i_fill_frame;
        end
    end

    assign o_fill_ready = !busy;
    assign o_af_wr_en   = push;
    assign o_wdf_wr_en  = push;

    // Same color in every pixel slot
    always_comb begin
        o_af_entry.cmd  = CMD_WRITE;
        o_af_entry.addr = word_addr(32'(frame), 32'(word));
        for (int p = 0; p < `PIXELS_PER_WORD; p++) begin
            o_wdf_din.pixels[p] = `PIXEL_BITS'(color);
        end
    end

    // A run ends on the last word of its frame
    a_run_end: assert property (@(posedge cpu_clk_g) disable iff (i_reset)
        $rose(o_fill_ready) |-> $past(o_af_wr_en &&
            (o_af_entry.addr[WORD_BITS-1:0] == WORD_BITS'(`FRAME_WORDS - 1))));

endmodule

/* source/request_controller.sv */
// Request controller
// Shares the memory queues between the frame filler and the pixel feeder
// Alternating slot pointer, gated full flags, read data routing

`timescale 1ns/1ps

module request_controller (
    input  logic               cpu_clk_g,
    input  logic               i_reset,
    // Frame filler, writes only
    input  logic               i_fill_af_wr_en,
    input  mem_pkg::af_entry_t i_fill_af_entry,
    input  logic               i_fill_wdf_wr_en,
    input  mem_pkg::mem_word_u i_fill_wdf_din,
    output logic               o_fill_af_full,
    output logic               o_fill_wdf_full,
    // Pixel feeder, reads only
    input  logic               i_pixel_af_wr_en,
    input  mem_pkg::af_entry_t i_pixel_af_entry,
    input  logic               i_pixel_rdf_rd_en,
    output logic               o_pixel_af_full,
    output logic               o_pixel_rdf_valid,
    output mem_pkg::mem_word_u o_pixel_rdf_dout,
    // Memory queues
    output logic               o_af_wr_en,
    output mem_pkg::af_entry_t o_af_entry,
    output logic               o_wdf_wr_en,
    output mem_pkg::mem_word_u o_wdf_din,
    input  logic               i_af_full,
    input  logic               i_wdf_full,
    input  logic               i_rdf_valid,
    input  mem_pkg::mem_word_u i_rdf_dout,
    output logic               o_rdf_rd_en
);

    // Slot owner, filler when high
    logic grant_fill;

    // Round robin, ownership alternates every cycle
    always_ff @(posedge cpu_clk_g) begin
        if (i_reset) begin
            grant_fill <= 1'b1;
        end else begin
            grant_fill <= !grant_fill;
        end
    end

    // ------------------------------
    // Back-pressure to the clients
    // ------------------------------
    // The client outside its slot sees the queues as full and holds
    assign o_fill_af_full  = i_af_full || !grant_fill;
    assign o_fill_wdf_full = i_wdf_full || !grant_fill;
    assign o_pixel_af_full = i_af_full || grant_fill;

    // ------------------------------
    // Forwarding to memory
    // ------------------------------
    assign o_af_wr_en  = grant_fill ? i_fill_af_wr_en : i_pixel_af_wr_en;
    assign o_af_entry  = grant_fill ? i_fill_af_entry : i_pixel_af_entry;
    assign o_wdf_wr_en = grant_fill && i_fill_wdf_wr_en;
    assign o_wdf_din   = i_fill_wdf_din;

    // Only the feeder reads, so all read data is its own
    assign o_pixel_rdf_valid = i_rdf_valid;
    assign o_pixel_rdf_dout  = i_rdf_dout;
    assign o_rdf_rd_en       = i_pixel_rdf_rd_en && i_rdf_valid;

    // Clients honour their slots, never two requests in one cycle
    a_one_client: assert property (@(posedge cpu_clk_g) disable iff (i_reset)
        !(i_fill_af_wr_en && i_pixel_af_wr_en));

    // No write data lands on a full queue
    a_wdf_room: assert property (@(posedge cpu_clk_g) disable iff (i_reset)
        o_wdf_wr_en |-> !i_wdf_full);

endmodule

/* source/dram_model.sv */
// Synchronous memory model with the DDR2 controller queue interface
// Address and write-data queues, frame storage, fixed-latency
// read pipeline and read-data queue

`timescale 1ns/1ps
`include "mem_defs.svh"

module dram_model (
    input  logic               cpu_clk_g,
    input  logic               i_reset,
    input  logic               i_af_wr_en,
    input  mem_pkg::af_entry_t i_af_entry,
    output logic               o_af_full,
    input  logic               i_wdf_wr_en,
    input  mem_pkg::mem_word_u i_wdf_din,
    output logic               o_wdf_full,
    output logic               o_rdf_valid,
    output mem_pkg::mem_word_u o_rdf_dout,
    input  logic               i_rdf_rd_en
);

    import mem_pkg::*;

    localparam int PTR_BITS      = $clog2(`QUEUE_DEPTH);
    localparam int CNT_BITS      = PTR_BITS + 1;
    localparam int MEM_ADDR_BITS = $clog2(`MEM_DEPTH);
    localparam int LAST          = `READ_LATENCY - 1;

    logic [`MEM_WORD_BITS-1:0] mem [`MEM_DEPTH];

    // Queue storage and pointers
    af_entry_t                 af_q [`QUEUE_DEPTH];
    logic [`MEM_WORD_BITS-1:0] wdf_q [`QUEUE_DEPTH];
    logic [`MEM_WORD_BITS-1:0] rdf_q [`QUEUE_DEPTH];
    logic [PTR_BITS-1:0]       af_wr_ptr;
    logic [PTR_BITS-1:0]       af_rd_ptr;
    logic [PTR_BITS-1:0]       wdf_wr_ptr;
    logic [PTR_BITS-1:0]       wdf_rd_ptr;
    logic [PTR_BITS-1:0]       rdf_wr_ptr;
    logic [PTR_BITS-1:0]       rdf_rd_ptr;
    logic [CNT_BITS-1:0]       af_count;
    logic [CNT_BITS-1:0]       wdf_count;
    logic [CNT_BITS-1:0]       rdf_count;

    // Read pipeline
    logic [LAST:0]             pipe_valid;
    logic [`MEM_WORD_BITS-1:0] pipe_data [`READ_LATENCY];

    af_entry_t                 head;
    logic [MEM_ADDR_BITS-1:0]  head_addr;
    logic                      rdf_room;
    logic                      do_write;
    logic                      do_read;
    logic                      af_pop;
    logic                      rdf_pop;

    assign head      = af_q[af_rd_ptr];
    assign head_addr = head.addr[MEM_ADDR_BITS-1:0];

    // Reads in flight plus queued data must fit the read queue
    assign rdf_room = (int'(rdf_count) + $countones(pipe_valid)) < `QUEUE_DEPTH;
    assign do_write = (af_count != '0) && (head.cmd == CMD_WRITE);
    assign do_read  = (af_count != '0) && (head.cmd == CMD_READ) && rdf_room;
    assign af_pop   = do_write || do_read;
    assign rdf_pop  = i_rdf_rd_en && o_rdf_valid;

    always_ff @(posedge cpu_clk_g) begin
        if (i_reset) begin
            af_wr_ptr  <= '0;
            af_rd_ptr  <= '0;
            wdf_wr_ptr <= '0;
            wdf_rd_ptr <= '0;
            rdf_wr_ptr <= '0;
            rdf_rd_ptr <= '0;
            af_count   <= '0;
            wdf_count  <= '0;
            rdf_count  <= '0;
            pipe_valid <= '0;
        end else begin
            af_wr_ptr  <= af_wr_ptr + PTR_BITS'(i_af_wr_en);
            af_rd_ptr  <= af_rd_ptr + PTR_BITS'(af_pop);
            wdf_wr_ptr <= wdf_wr_ptr + PTR_BITS'(i_wdf_wr_en);
            wdf_rd_ptr <= wdf_rd_ptr + PTR_BITS'(do_write);
            rdf_wr_ptr <= rdf_wr_ptr + PTR_BITS'(pipe_valid[LAST]);
            rdf_rd_ptr <= rdf_rd_ptr + PTR_BITS'(rdf_pop);
            af_count   <= af_count + CNT_BITS'(i_af_wr_en) - CNT_BITS'(af_pop);
            wdf_count  <= wdf_count + CNT_BITS'(i_wdf_wr_en) - CNT_BITS'(do_write);
            rdf_count  <= rdf_count + CNT_BITS'(pipe_valid[LAST]) - CNT_BITS'(rdf_pop);
            pipe_valid <= {pipe_valid[LAST-1:0], do_read};
        end
    end

    // Storage and data path
    always_ff @(posedge cpu_clk_g) begin
        if (i_af_wr_en) begin
            af_q[af_wr_ptr] <= i_af_entry;
        end
        if (i_wdf_wr_en) begin
            wdf_q[wdf_wr_ptr] <= i_wdf_din.raw;
        end
        if (do_write) begin
            mem[head_addr] <= wdf_q[wdf_rd_ptr];
        end
        pipe_data[0] <= mem[head_addr];
        for (int s = 1; s < `READ_LATENCY; s++) begin
            pipe_data[s] <= pipe_data[s-1];
        end
        if (pipe_valid[LAST]) begin
            rdf_q[rdf_wr_ptr] <= pipe_data[LAST];
        end
    end

    // Full one entry early so a request already in flight still fits
    assign o_af_full      = af_count >= CNT_BITS'(`QUEUE_DEPTH - 1);
    assign o_wdf_full     = wdf_count >= CNT_BITS'(`QUEUE_DEPTH - 1);
    assign o_rdf_valid    = rdf_count != '0;
    assign o_rdf_dout.raw = rdf_q[rdf_rd_ptr];

    // Writer pushes command and data together, so data is always there
    a_wdf_ready: assert property (@(posedge cpu_clk_g) disable iff (i_reset)
        do_write |-> wdf_count != '0);

endmodule

/* source/pixel_feeder.sv */
// Pixel feeder
// Reads one frame back word by word and streams its pixels
// on the video port, then pulses the frame interrupt

`timescale 1ns/1ps
`include "mem_defs.svh"

module pixel_feeder (
    input  logic                       cpu_clk_g,
    input  logic                       i_reset,
    // Display request
    input  logic                       i_display_valid,
    input  logic [`FRAME_SEL_BITS-1:0] i_display_frame,
    output logic                       o_display_ready,
    // Video stream
    output logic [`COLOR_BITS-1:0]     o_video,
    output logic                       o_video_valid,
    input  logic                       i_video_ready,
    output logic                       o_frame_interrupt,
    // Read path toward the request controller
    output logic                       o_af_wr_en,
    output mem_pkg::af_entry_t         o_af_entry,
    input  logic                       i_af_full,
    input  logic                       i_rdf_valid,
    input  mem_pkg::mem_word_u         i_rdf_dout,
    output logic                       o_rdf_rd_en
);

    import mem_pkg::*;

    localparam int WORD_BITS = $clog2(`FRAME_WORDS);
    localparam int OUT_BITS  = $clog2(`QUEUE_DEPTH) + 1;
    localparam int SLOT_BITS = $clog2(`PIXELS_PER_WORD);

    logic                       active;
    logic [`FRAME_SEL_BITS-1:0] frame;
    logic [WORD_BITS:0]         rd_word;
    logic [WORD_BITS-1:0]       out_word;
    logic [OUT_BITS-1:0]        outstanding;
    mem_word_u                  word;
    logic                       word_valid;
    logic [SLOT_BITS-1:0]       slot;
    logic                       issue;
    logic                       pix_take;
    logic                       word_done;
    logic                       last_pixel;

    // Read issue, bounded by the reads still owed and the buffer space
    assign issue = active && (32'(rd_word) < `FRAME_WORDS) &&
                   (outstanding < OUT_BITS'(`QUEUE_DEPTH)) && !i_af_full;

    assign pix_take   = word_valid && i_video_ready;
    assign word_done  = pix_take && (slot == SLOT_BITS'(`PIXELS_PER_WORD - 1));
    assign last_pixel = word_done && (out_word == WORD_BITS'(`FRAME_WORDS - 1));

    // Next word loads as the current one drains
    assign o_rdf_rd_en = i_rdf_valid && (!word_valid || word_done);

    always_ff @(posedge cpu_clk_g) begin
        if (i_reset) begin
            active            <= 1'b0;
            rd_word           <= '0;
            out_word          <= '0;
            outstanding       <= '0;
            word_valid        <= 1'b0;
            slot              <= '0;
            o_frame_interrupt <= 1'b0;
        end else begin
            o_frame_interrupt <= last_pixel;
            if (!active && i_display_valid) begin
                active   <= 1'b1;
                rd_word  <= '0;
                out_word <= '0;
                slot     <= '0;
            end else begin
                // Ready returns the cycle after the interrupt pulse
                if (o_frame_interrupt) begin
                    active <= 1'b0;
                end
                if (issue) begin
                    rd_word <= rd_word + 1'b1;
                end
                if (pix_take) begin
                    slot <= slot + 1'b1;
                end
                if (word_done) begin
                    out_word <= out_word + 1'b1;
                end
            end
            outstanding <= outstanding + OUT_BITS'(issue) - OUT_BITS'(o_rdf_rd_en);
            if (o_rdf_rd_en) begin
                word_valid <= 1'b1;
            end else if (word_done) begin
                word_valid <= 1'b0;
            end
        end
    end

    // Frame index and current word
    always_ff @(posedge cpu_clk_g) begin
        if (!active && i_display_valid) begin
            frame <= i_display_frame;
        end
        if (o_rdf_rd_en) begin
            word <= i_rdf_dout;
        end
    end

    assign o_display_ready = !active;
    assign o_video_valid   = word_valid;
    assign o_video         = word.pixels[slot][`COLOR_BITS-1:0];
    assign o_af_wr_en      = issue;

    always_comb begin
        o_af_entry.cmd  = CMD_READ;
        o_af_entry.addr = word_addr(32'(frame), 32'(rd_word));
    end

    // A pixel on offer holds until the display takes it
    a_video_hold: assert property (@(posedge cpu_clk_g) disable iff (i_reset)
        (o_video_valid && !i_video_ready) |=> (o_video_valid && $stable(o_video)));

endmodule

/* source/memory_top.sv */
// Graphics memory subsystem top level
// Frame filler, pixel feeder, request controller and memory model

`timescale 1ns/1ps
`include "mem_defs.svh"

module memory_top (
    input  logic                       cpu_clk_g,
    input  logic                       i_reset,
    // Fill request
    input  logic                       i_fill_valid,
    input  logic [`COLOR_BITS-1:0]     i_fill_color,
    input  logic [`FRAME_SEL_BITS-1:0] i_fill_frame,
    output logic                       o_fill_ready,
    // Display request
    input  logic                       i_display_valid,
    input  logic [`FRAME_SEL_BITS-1:0] i_display_frame,
    output logic                       o_display_ready,
    // Video stream
    output logic [`COLOR_BITS-1:0]     o_video,
    output logic                       o_video_valid,
    input  logic                       i_video_ready,
    output logic                       o_frame_interrupt
);

    import mem_pkg::*;

    // Filler to controller
    logic      fill_af_wr_en;
    af_entry_t fill_af_entry;
    logic      fill_wdf_wr_en;
    mem_word_u fill_wdf_din;
    logic      fill_af_full;
    logic      fill_wdf_full;

    // Feeder to controller
    logic      pixel_af_wr_en;
    af_entry_t pixel_af_entry;
    logic      pixel_af_full;
    logic      pixel_rdf_rd_en;
    logic      pixel_rdf_valid;
    mem_word_u pixel_rdf_dout;

    // Controller to memory
    logic      af_wr_en;
    af_entry_t af_entry;
    logic      wdf_wr_en;
    mem_word_u wdf_din;
    logic      af_full;
    logic      wdf_full;
    logic      rdf_valid;
    mem_word_u rdf_dout;
    logic      rdf_rd_en;

    frame_filler u_filler (
        .cpu_clk_g    (cpu_clk_g),
        .i_reset      (i_reset),
        .i_fill_valid (i_fill_valid),
        .i_fill_color (i_fill_color),
        .i_fill_frame (i_fill_frame),
        .o_fill_ready (o_fill_ready),
        .i_af_full    (fill_af_full),
        .i_wdf_full   (fill_wdf_full),
        .o_af_wr_en   (fill_af_wr_en),
        .o_af_entry   (fill_af_entry),
        .o_wdf_wr_en  (fill_wdf_wr_en),
        .o_wdf_din    (fill_wdf_din)
    );

    request_controller u_ctrl (
        .cpu_clk_g         (cpu_clk_g),
        .i_reset           (i_reset),
        .i_fill_af_wr_en   (fill_af_wr_en),
        .i_fill_af_entry   (fill_af_entry),
        .i_fill_wdf_wr_en  (fill_wdf_wr_en),
        .i_fill_wdf_din    (fill_wdf_din),
        .o_fill_af_full    (fill_af_full),
        .o_fill_wdf_full   (fill_wdf_full),
        .i_pixel_af_wr_en  (pixel_af_wr_en),
        .i_pixel_af_entry  (pixel_af_entry),
        .i_pixel_rdf_rd_en (pixel_rdf_rd_en),
        .o_pixel_af_full   (pixel_af_full),
        .o_pixel_rdf_valid (pixel_rdf_valid),
        .o_pixel_rdf_dout  (pixel_rdf_dout),
        .o_af_wr_en        (af_wr_en),
        .o_af_entry        (af_entry),
        .o_wdf_wr_en       (wdf_wr_en),
        .o_wdf_din         (wdf_din),
        .i_af_full         (af_full),
        .i_wdf_full        (wdf_full),
        .i_rdf_valid       (rdf_valid),
        .i_rdf_dout        (rdf_dout),
        .o_rdf_rd_en       (rdf_rd_en)
    );

    dram_model u_dram (
        .cpu_clk_g   (cpu_clk_g),
        .i_reset     (i_reset),
        .i_af_wr_en  (af_wr_en),
        .i_af_entry  (af_entry),
        .o_af_full   (af_full),
        .i_wdf_wr_en (wdf_wr_en),
        .i_wdf_din   (wdf_din),
        .o_wdf_full  (wdf_full),
        .o_rdf_valid (rdf_valid),
        .o_rdf_dout  (rdf_dout),
        .i_rdf_rd_en (rdf_rd_en)
    );

    pixel_feeder u_feeder (
        .cpu_clk_g         (cpu_clk_g),
        .i_reset           (i_reset),
        .i_display_valid   (i_display_valid),
        .i_display_frame   (i_display_frame),
        .o_display_ready   (o_display_ready),
        .o_video           (o_video),
        .o_video_valid     (o_video_valid),
        .i_video_ready     (i_video_ready),
        .o_frame_interrupt (o_frame_interrupt),
        .o_af_wr_en        (pixel_af_wr_en),
        .o_af_entry        (pixel_af_entry),
        .i_af_full         (pixel_af_full),
        .i_rdf_valid       (pixel_rdf_valid),
        .i_rdf_dout        (pixel_rdf_dout),
        .o_rdf_rd_en       (pixel_rdf_rd_en)
    );

endmodule

/* verification/tb_clock.sv */
// Clock and reset source for the testbench
// 40 ns clock period, synchronous reset held for three rising edges

`timescale 1ns/1ps

module tb_clock (
    output logic o_clk,
    output logic o_reset
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 3;

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    // Reset drops on a rising edge, like any other driven input
    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_reset <= 1'b0;
    end

endmodule

/* verification/tb_memory.sv */
// Testbench for the graphics memory subsystem
// Fill and display sequences, reference frame colors,
// pixel stream checker and the closing report

`timescale 1ns/1ps
`include "mem_defs.svh"

module tb_memory;

    localparam int WAIT_LIMIT     = 2000;
    localparam int FRAME_PIXELS   = `FRAME_WORDS * `PIXELS_PER_WORD;
    localparam int SEL_BITS       = `FRAME_SEL_BITS;
    localparam int SEL_RESET_DONE = 0;
    localparam int SEL_FILL       = 1;
    localparam int SEL_DISPLAY    = 2;
    localparam int SEL_IRQ        = 3;

    logic                   clk;
    logic                   reset;
    logic                   i_fill_valid;
    logic [`COLOR_BITS-1:0] i_fill_color;
    logic [SEL_BITS-1:0]    i_fill_frame;
    logic                   o_fill_ready;
    logic                   i_display_valid;
    logic [SEL_BITS-1:0]    i_display_frame;
    logic                   o_display_ready;
    logic [`COLOR_BITS-1:0] o_video;
    logic                   o_video_valid;
    logic                   i_video_ready = 1'b0;
    logic                   o_frame_interrupt;

    // Reference model of the last color written to each frame
    logic [`COLOR_BITS-1:0] ref_color [`FRAME_COUNT];

    // Checker state
    int                     disp_frame  = 0;
    int                     pixel_count = 0;
    int                     irq_count   = 0;
    logic                   held_valid  = 1'b0;
    logic [`COLOR_BITS-1:0] held_video  = '0;
    logic                   random_ready;

    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;

    tb_clock u_clock (
        .o_clk   (clk),
        .o_reset (reset)
    );

    memory_top u_dut (
        .cpu_clk_g         (clk),
        .i_reset           (reset),
        .i_fill_valid      (i_fill_valid),
        .i_fill_color      (i_fill_color),
        .i_fill_frame      (i_fill_frame),
        .o_fill_ready      (o_fill_ready),
        .i_display_valid   (i_display_valid),
        .i_display_frame   (i_display_frame),
        .o_display_ready   (o_display_ready),
        .o_video           (o_video),
        .o_video_valid     (o_video_valid),
        .i_video_ready     (i_video_ready),
        .o_frame_interrupt (o_frame_interrupt)
    );

    // ------------------------------
    // Reference and helpers
    // ------------------------------
    // Every pixel of a frame carries the frame's fill color
    function automatic logic [`COLOR_BITS-1:0] expected_pixel(input int frame);
        return ref_color[frame];
    endfunction

    function automatic logic [`COLOR_BITS-1:0] fresh_color(input logic [`COLOR_BITS-1:0] avoid);
        logic [`COLOR_BITS-1:0] color;
        color = `COLOR_BITS'($urandom);
        if (color == avoid) begin
            color = ~avoid;
        end
        return color;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0d ns: %s = %0h, expected %0h", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic abort_run(input string reason);
        $display("Timeout at %0d ns: %s never happened", $time, reason);
        $display("** FAIL **");
        $finish;
    endtask

    function automatic logic watched(input int sel);
        case (sel)
            SEL_RESET_DONE: return !reset;
            SEL_FILL:       return o_fill_ready;
            SEL_DISPLAY:    return o_display_ready;
            default:        return o_frame_interrupt;
        endcase
    endfunction

    // Returns on the first rising edge that sees the selected signal high
    task automatic wait_for(input int sel, input string what);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!watched(sel) && cycles < WAIT_LIMIT);
        if (!watched(sel)) begin
            abort_run(what);
        end
    endtask

    task automatic drive_fill(input int frame, input logic [`COLOR_BITS-1:0] color);
        i_fill_valid     <= 1'b1;
        i_fill_frame     <= SEL_BITS'(frame);
        i_fill_color     <= color;
        ref_color[frame] = color;
    endtask

    task automatic drive_display(input int frame);
        i_display_valid <= 1'b1;
        i_display_frame <= SEL_BITS'(frame);
    endtask

    // One-cycle request strobes
    task automatic release_requests();
        @(posedge clk);
        i_fill_valid    <= 1'b0;
        i_display_valid <= 1'b0;
    endtask

    task automatic fill_frame(input int frame, input logic [`COLOR_BITS-1:0] color);
        wait_for(SEL_FILL, "fill ready before request");
        drive_fill(frame, color);
        release_requests();
    endtask

    task automatic finish_display();
        wait_for(SEL_IRQ, "frame interrupt");
        wait_for(SEL_DISPLAY, "display ready after frame");
        @(negedge clk);
        check_value("pixel count", pixel_count, FRAME_PIXELS);
        check_value("interrupt pulses", irq_count, 1);
    endtask

    task automatic display_frame(input int frame);
        wait_for(SEL_DISPLAY, "display ready before request");
        drive_display(frame);
        release_requests();
        finish_display();
    endtask

    task automatic finish_test(input int num, input string name);
        tests_run++;
        if (errors != test_errors) begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", num, name, errors - test_errors);
        end else begin
            $display("Test %0d %s: passed", num, name);
        end
        test_errors = errors;
    endtask

    // ------------------------------
    // Video ready driver
    // ------------------------------
    always @(posedge clk) begin
        if (random_ready) begin
            i_video_ready <= 1'($urandom_range(1, 0));
        end else begin
            i_video_ready <= 1'b1;
        end
    end

    // ------------------------------
    // Pixel stream checker
    // ------------------------------
    always @(posedge clk) begin
        if (reset) begin
            held_valid = 1'b0;
        end else begin
            if (i_display_valid && o_display_ready) begin
                disp_frame  = int'(i_display_frame);
                pixel_count = 0;
                irq_count   = 0;
            end
            // A pixel on offer must not move until taken
            if (held_valid) begin
                check_value("o_video_valid", o_video_valid, 1);
                check_value("o_video", o_video, held_video);
            end
            if (o_video_valid && i_video_ready) begin
                check_value("o_video", o_video, expected_pixel(disp_frame));
                pixel_count++;
            end
            // Interrupt only after the whole frame went out
            if (o_frame_interrupt) begin
                check_value("pixels before interrupt", pixel_count, FRAME_PIXELS);
                irq_count++;
            end
            held_valid = o_video_valid && !i_video_ready;
            held_video = o_video;
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        logic [`COLOR_BITS-1:0] color_a;
        logic [`COLOR_BITS-1:0] color_b;
        void'($urandom(54));
        i_fill_valid    = 1'b0;
        i_fill_color    = '0;
        i_fill_frame    = '0;
        i_display_valid = 1'b0;
        i_display_frame = '0;
        random_ready    = 1'b0;
        ref_color[0]    = '0;
        ref_color[1]    = '0;
        errors          = 0;
        test_errors     = 0;
        tests_run       = 0;
        tests_failed    = 0;

        wait_for(SEL_RESET_DONE, "reset release");
        check_value("o_fill_ready", o_fill_ready, 1);
        check_value("o_display_ready", o_display_ready, 1);
        check_value("o_video_valid", o_video_valid, 0);
        check_value("o_frame_interrupt", o_frame_interrupt, 0);
        finish_test(1, "reset state");

        color_a = fresh_color(ref_color[0]);
        fill_frame(0, color_a);
        wait_for(SEL_FILL, "end of fill");
        display_frame(0);
        finish_test(2, "fill and display one frame");

        // Distinct colors expose a wrong frame base
        color_a = fresh_color(ref_color[0]);
        color_b = fresh_color(color_a);
        fill_frame(0, color_a);
        fill_frame(1, color_b);
        wait_for(SEL_FILL, "end of fill");
        display_frame(1);
        display_frame(0);
        finish_test(3, "two frames");

        random_ready = 1'b1;
        display_frame(1);
        random_ready = 1'b0;
        finish_test(4, "video back-pressure");

        // Filler and feeder compete for the memory queues
        color_a = fresh_color(ref_color[1]);
        wait_for(SEL_FILL, "fill ready before request");
        wait_for(SEL_DISPLAY, "display ready before request");
        drive_fill(1, color_a);
        drive_display(0);
        release_requests();
        finish_display();
        wait_for(SEL_FILL, "end of fill");
        display_frame(1);
        finish_test(5, "fill during display");

        color_a = fresh_color(ref_color[0]);
        fill_frame(0, color_a);
        wait_for(SEL_FILL, "end of fill");
        display_frame(0);
        finish_test(6, "read after write");

        $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+source
source/mem_pkg.sv
source/frame_filler.sv
source/request_controller.sv
source/dram_model.sv
source/pixel_feeder.sv
source/memory_top.sv
verification/tb_clock.sv
verification/tb_memory.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log
set -e

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_memory -f sources.f -Mdir obj_dir -o sim_memory

./obj_dir/sim_memory > sim.log 2>&1
cat sim.log

if grep -qF '** FAIL **' sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -qF '** PASS **' sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
